//--- logic/lcdPkg.sv
package lcdPkg;

	////////////////////////////////////////////////////////////
	// Data types on the LCD side
	////////////////////////////////////////////////////////////

	typedef logic [3:0] nibbleT;                         // Value on the four data pins
	typedef logic [7:0] byteT;                           // Character or command byte

	// Settle class that follows one nibble step
	typedef enum logic [2:0]
	{
		waitPowerOn,                                     // Power-on delay before any nibble
		waitInit1,                                       // After first wake nibble
		waitInit2,                                       // After second wake nibble
		waitInit3,                                       // After third wake nibble
		waitShort,                                       // After an upper nibble
		waitCommand,                                     // After a lower nibble
		waitClear                                        // After the clear command
	} waitT;

	// Sequencer phases
	typedef enum logic [2:0]
	{
		phaseBoot,                                       // First cycle out of reset
		phaseInit,                                       // Walking the power-on and config list
		phaseIdle,                                       // Ready for a character
		phaseCharUpper,                                  // Upper character nibble in flight
		phaseCharLower                                   // Lower character nibble in flight
	} seqPhaseT;

	////////////////////////////////////////////////////////////
	// Timing
	////////////////////////////////////////////////////////////

	localparam int WaitKinds = 7;                        // Entries in waitT
	localparam int WaitCountWidth = 32;                  // Shared step timer width
	localparam int EnableCycles = 12;                    // Enable high time in clocks

	// Microseconds per settle class, indexed by waitT
	localparam int unsigned waitMicros [WaitKinds] = '{
		15000,                                           // waitPowerOn
		4100,                                            // waitInit1
		100,                                             // waitInit2
		40,                                              // waitInit3
		1,                                               // waitShort
		40,                                              // waitCommand
		1640                                             // waitClear
	};

	////////////////////////////////////////////////////////////
	// HD44780 codes
	////////////////////////////////////////////////////////////

	localparam byteT CmdFunctionSet = 8'h28;             // 4-bit bus, two lines, 5x8 font
	localparam byteT CmdEntryMode = 8'h06;               // Cursor increments, no shift
	localparam byteT CmdDisplayControl = 8'h0C;          // Display on, cursor off
	localparam byteT CmdClear = 8'h01;                   // Clear and home

	localparam nibbleT InitNibbleWake = 4'h3;            // Sent three times at power-on
	localparam nibbleT InitNibbleFourBit = 4'h2;         // Switches the panel to 4-bit mode

	////////////////////////////////////////////////////////////
	// Power-on step list layout
	////////////////////////////////////////////////////////////

	// Step 0 is the bare power-on wait, steps 1..3 the wake nibbles,
	// step 4 the 4-bit switch, then two steps per config command
	localparam int WakeFirstStep = 1;
	localparam int FourBitStep = 4;
	localparam int ConfigFirstStep = 5;
	localparam int InitStepCount = 13;                   // 5 power-on steps plus 8 config steps
	localparam int StepIndexWidth = $clog2(InitStepCount);
	localparam int LastInitStep = InitStepCount - 1;

endpackage

//--- logic/lcdSequencer.sv
`timescale 1ns/1ps

module lcdSequencer
(
	input  logic           Clock,
	input  logic           rstN,                       // Synchronous, active low
	input  lcdPkg::byteT   dataIn,                     // Character from the user
	input  logic           dataValid,                  // User has a character
	output logic           dataReady,                  // Idle and able to take a character
	input  logic           stepBusy,                   // Writer still in a step
	output logic           stepStart,                  // One-cycle step launch
	output lcdPkg::nibbleT stepNibble,                 // Nibble for the step
	output logic           stepRegSelect,              // High for character data
	output logic           stepPulse,                  // Step carries an enable pulse
	output lcdPkg::waitT   stepWait                    // Settle class after the step
);

	import lcdPkg::*;

	////////////////////////////////////////////////////////////
	// State
	////////////////////////////////////////////////////////////

	seqPhaseT                  phase;                  // Current phase
	logic [StepIndexWidth-1:0] stepIndex;              // Position in power-on list
	logic [StepIndexWidth-1:0] launchIndex;            // List entry to launch next
	logic [StepIndexWidth-1:0] cfgOffset;              // Offset inside config part
	logic                      busyPrev;               // stepBusy one cycle ago
	logic                      stepDone;               // Falling edge of stepBusy
	logic                      transfer;               // Character handshake this cycle
	byteT                      charByte;               // Held character for its lower nibble
	byteT                      cfgCommand;             // Config command of launchIndex

	// Fields of the list entry at launchIndex
	nibbleT                    initNibble;
	logic                      initPulse;
	waitT                      initWait;

	// Fields of whatever step launches this cycle
	logic                      launch;
	nibbleT                    nextNibble;
	logic                      nextRegSelect;
	logic                      nextPulse;
	waitT                      nextWait;

	assign stepDone = busyPrev & ~stepBusy;            // Completion event
	assign transfer = dataReady & dataValid;
	assign launchIndex = (phase == phaseBoot) ? '0 : StepIndexWidth'(stepIndex + 1'b1);
	assign cfgOffset = StepIndexWidth'(launchIndex - ConfigFirstStep);

	////////////////////////////////////////////////////////////
	// Power-on and config list decode
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (cfgOffset[2:1])                          // Two steps per command
			2'd0: cfgCommand = CmdFunctionSet;
			2'd1: cfgCommand = CmdEntryMode;
			2'd2: cfgCommand = CmdDisplayControl;
			default: cfgCommand = CmdClear;
		endcase
	end

	always_comb
	begin
		initNibble = InitNibbleWake;
		initPulse = 1'b1;
		initWait = waitCommand;
		if (launchIndex == '0)
		begin
			initNibble = '0;                           // Pins idle during the power-on wait
			initPulse = 1'b0;
			initWait = waitPowerOn;
		end
		else if (launchIndex < StepIndexWidth'(FourBitStep))
		begin
			case (launchIndex - StepIndexWidth'(WakeFirstStep))
				2'd0: initWait = waitInit1;            // 4.1 ms
				2'd1: initWait = waitInit2;            // 100 us
				default: initWait = waitInit3;         // 40 us
			endcase
		end
		else if (launchIndex == StepIndexWidth'(FourBitStep))
			initNibble = InitNibbleFourBit;
		else if (!cfgOffset[0])
		begin
			initNibble = cfgCommand[7:4];              // Upper nibble first
			initWait = waitShort;
		end
		else
		begin
			initNibble = cfgCommand[3:0];
			initWait = (cfgCommand == CmdClear) ? waitClear : waitCommand;
		end
	end

	////////////////////////////////////////////////////////////
	// Launch select
	////////////////////////////////////////////////////////////

	always_comb
	begin
		launch = 1'b0;
		nextNibble = initNibble;
		nextRegSelect = 1'b0;                          // Commands by default
		nextPulse = initPulse;
		nextWait = initWait;
		case (phase)
			phaseBoot: launch = 1'b1;                  // Power-on wait right out of reset
			phaseInit: launch = stepDone && (stepIndex != StepIndexWidth'(LastInitStep));
			phaseIdle:
			begin
				launch = transfer;
				nextNibble = dataIn[7:4];
				nextRegSelect = 1'b1;
				nextPulse = 1'b1;
				nextWait = waitShort;
			end
			phaseCharUpper:
			begin
				launch = stepDone;
				nextNibble = charByte[3:0];
				nextRegSelect = 1'b1;
				nextPulse = 1'b1;
				nextWait = waitCommand;
			end
			default: launch = 1'b0;                    // Lower nibble finishing
		endcase
	end

	////////////////////////////////////////////////////////////
	// Control registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			phase <= phaseBoot;
			stepIndex <= '0;
			busyPrev <= 1'b0;
			stepStart <= 1'b0;
			dataReady <= 1'b0;
		end
		else
		begin
			busyPrev <= stepBusy;
			stepStart <= launch;                       // Registered one-cycle pulse
			case (phase)
				phaseBoot: phase <= phaseInit;
				phaseInit:
				begin
					if (stepDone && stepIndex == StepIndexWidth'(LastInitStep))
					begin
						phase <= phaseIdle;            // Clear has settled
						dataReady <= 1'b1;
					end
					else if (launch)
						stepIndex <= launchIndex;
				end
				phaseIdle:
				begin
					if (transfer)
					begin
						phase <= phaseCharUpper;
						dataReady <= 1'b0;             // Drops the cycle after a transfer
					end
				end
				phaseCharUpper:
				begin
					if (stepDone)
						phase <= phaseCharLower;
				end
				default:
				begin
					if (stepDone)
					begin
						phase <= phaseIdle;
						dataReady <= 1'b1;
					end
				end
			endcase
		end
	end

	// Step fields and held character
	always_ff @(posedge Clock)
	begin
		if (launch)
		begin
			stepNibble <= nextNibble;
			stepRegSelect <= nextRegSelect;
			stepPulse <= nextPulse;
			stepWait <= nextWait;
		end
		if (transfer)
			charByte <= dataIn;
	end

endmodule

//--- logic/lcdNibbleWriter.sv
`timescale 1ns/1ps

module lcdNibbleWriter
#(
	parameter int ClockMhz = 50                        // Clock rate that scales the waits
)
(
	input  logic           Clock,
	input  logic           rstN,                       // Synchronous, active low
	input  logic           stepStart,                  // One-cycle step launch
	input  lcdPkg::nibbleT stepNibble,
	input  logic           stepRegSelect,
	input  logic           stepPulse,                  // Pulse phase wanted
	input  lcdPkg::waitT   stepWait,
	output logic           stepBusy,                   // High until the settle wait ends
	output logic           lcdEnable,                  // LCD E pin
	output logic           lcdRegSelect,               // LCD RS pin
	output lcdPkg::nibbleT lcdData                     // LCD DB7..DB4
);

	import lcdPkg::*;

	////////////////////////////////////////////////////////////
	// Step timer
	////////////////////////////////////////////////////////////

	logic [WaitCountWidth-1:0] timeCount;              // Cycles left in current phase
	waitT                      settleClass;            // Wait class of the step in flight
	logic                      accept;                 // Step taken this cycle

	// Settle length in clocks, never below one
	function automatic logic [WaitCountWidth-1:0] settleCycles(input waitT kind);
		logic [WaitCountWidth-1:0] cycles;
		cycles = WaitCountWidth'(waitMicros[kind]) * WaitCountWidth'(ClockMhz);
		if (cycles == '0)
			cycles = WaitCountWidth'(1);
		return cycles;
	endfunction

	assign accept = stepStart & ~stepBusy;

	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			stepBusy <= 1'b0;
			lcdEnable <= 1'b0;
			lcdRegSelect <= 1'b0;
			lcdData <= '0;
			timeCount <= '0;
		end
		else if (accept)
		begin
			stepBusy <= 1'b1;
			lcdEnable <= stepPulse;                    // Pulse phase first when asked
			lcdRegSelect <= stepRegSelect;             // Pins held until next step
			lcdData <= stepNibble;
			if (stepPulse)
				timeCount <= WaitCountWidth'(EnableCycles - 1);
			else
				timeCount <= settleCycles(stepWait) - 1'b1;
		end
		else if (stepBusy)
		begin
			if (timeCount != '0)
				timeCount <= timeCount - 1'b1;
			else if (lcdEnable)
			begin
				lcdEnable <= 1'b0;                     // End of pulse
				timeCount <= settleCycles(settleClass) - 1'b1;
			end
			else
				stepBusy <= 1'b0;                      // Settle done
		end
	end

	// Wait class kept for the settle phase
	always_ff @(posedge Clock)
	begin
		if (accept)
			settleClass <= stepWait;
	end

endmodule

//--- logic/lcdController.sv
`timescale 1ns/1ps

module lcdController
#(
	parameter int ClockMhz = 50                        // System clock in MHz
)
(
	input  logic           Clock,
	input  logic           rstN,                       // Synchronous, active low
	input  lcdPkg::byteT   dataIn,                     // Character to show
	input  logic           dataValid,
	output logic           dataReady,
	output logic           lcdEnable,                  // E
	output logic           lcdRegSelect,               // RS
	output logic           lcdReadWrite,               // RW
	output lcdPkg::nibbleT lcdData                     // DB7..DB4
);

	import lcdPkg::*;

	////////////////////////////////////////////////////////////
	// Sequencer to writer
	////////////////////////////////////////////////////////////

	logic   stepStart;
	logic   stepBusy;
	nibbleT stepNibble;
	logic   stepRegSelect;
	logic   stepPulse;
	waitT   stepWait;

	assign lcdReadWrite = 1'b0;                        // Write only

	lcdSequencer i_sequencer
	(
		.Clock         (Clock),
		.rstN          (rstN),
		.dataIn        (dataIn),
		.dataValid     (dataValid),
		.dataReady     (dataReady),
		.stepBusy      (stepBusy),
		.stepStart     (stepStart),
		.stepNibble    (stepNibble),
		.stepRegSelect (stepRegSelect),
		.stepPulse     (stepPulse),
		.stepWait      (stepWait)
	);

	lcdNibbleWriter #(.ClockMhz(ClockMhz)) i_writer
	(
		.Clock         (Clock),
		.rstN          (rstN),
		.stepStart     (stepStart),
		.stepNibble    (stepNibble),
		.stepRegSelect (stepRegSelect),
		.stepPulse     (stepPulse),
		.stepWait      (stepWait),
		.stepBusy      (stepBusy),
		.lcdEnable     (lcdEnable),
		.lcdRegSelect  (lcdRegSelect),
		.lcdData       (lcdData)
	);

endmodule

//--- bench/lcdController_props.sv
`timescale 1ns/1ps

module lcdControllerProps
(
	input logic           Clock,
	input logic           rstN,                        // Synchronous, active low
	input logic           dataReady,
	input logic           lcdEnable,
	input logic           lcdRegSelect,
	input lcdPkg::nibbleT lcdData
);

	import lcdPkg::*;

	////////////////////////////////////////////////////////////
	// LCD pin protocol
	////////////////////////////////////////////////////////////

	enableWidth: assert property (@(posedge Clock) disable iff (!rstN)
		$rose(lcdEnable) |-> lcdEnable [*EnableCycles] ##1 !lcdEnable)    // Fixed E width
		else $error("lcdEnable high time differs from %0d cycles", EnableCycles);

	// Panel latches on the falling edge of E
	pinsStable: assert property (@(posedge Clock) disable iff (!rstN)
		lcdEnable && $past(lcdEnable) |-> $stable(lcdData) && $stable(lcdRegSelect))
		else $error("lcdData or lcdRegSelect changed while lcdEnable was high");

	////////////////////////////////////////////////////////////
	// Handshake and reset
	////////////////////////////////////////////////////////////

	readyQuiet: assert property (@(posedge Clock) disable iff (!rstN)
		lcdEnable |-> !dataReady)                                // No ready mid-pulse
		else $error("dataReady high while lcdEnable is high");

	resetState: assert property (@(posedge Clock)
		!rstN |=> !lcdEnable && !dataReady)                      // Outputs idle after reset
		else $error("lcdEnable or dataReady high on the cycle after reset");

endmodule

bind lcdController lcdControllerProps i_props
(
	.Clock        (Clock),
	.rstN         (rstN),
	.dataReady    (dataReady),
	.lcdEnable    (lcdEnable),
	.lcdRegSelect (lcdRegSelect),
	.lcdData      (lcdData)
);

//--- bench/lcdControllerTb.sv
`timescale 1ns/1ps

module lcdControllerTb;

	import lcdPkg::*;

	localparam int ClockMhz = 2;                         // Slow rate keeps the waits short
	localparam int InitPulses = 12;                      // 4 power-on plus 8 config nibbles
	localparam int CharCount = 20;                       // Random characters with gaps
	localparam int HoldCount = 4;                        // Back-to-back characters

	typedef logic [4:0] pulseT;                          // {register select, nibble}
	typedef pulseT pulseQT [$];
	typedef byteT byteQT [$];

	logic   Clock;
	logic   rstN;
	byteT   dataIn;
	logic   dataValid;
	logic   dataReady;
	logic   lcdEnable;
	logic   lcdRegSelect;
	logic   lcdReadWrite;
	nibbleT lcdData;

	pulseQT pulseQ;                                      // Pins seen at each E rise
	int     pulseCycle [$];                              // Cycle of each E rise
	byteQT  sentQ;                                       // Characters in transfer order
	int     cycleCount;
	logic   enablePrev;
	bit     readyEarlySeen;
	int     valueErrors;
	int     protocolErrors;
	int     seedValue;

	lcdController #(.ClockMhz(ClockMhz)) i_dut
	(
		.Clock        (Clock),
		.rstN         (rstN),
		.dataIn       (dataIn),
		.dataValid    (dataValid),
		.dataReady    (dataReady),
		.lcdEnable    (lcdEnable),
		.lcdRegSelect (lcdRegSelect),
		.lcdReadWrite (lcdReadWrite),
		.lcdData      (lcdData)
	);

	initial
	begin
		Clock = 1'b0;
		forever #4 Clock = ~Clock;                       // 8 ns period
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Settle time in clocks for one wait class
	function automatic int waitLength(input waitT kind);
		return waitMicros[kind] * ClockMhz;
	endfunction

	// Wait class that follows init pulse idx
	function automatic waitT initWaitAfter(input int idx);
		if (idx == 0)
			return waitInit1;
		if (idx == 1)
			return waitInit2;
		if (idx == 2)
			return waitInit3;
		if (idx == 3)
			return waitCommand;                          // After the 4-bit switch
		if ((idx - 4) % 2 == 0)
			return waitShort;                            // Upper command nibble
		return (idx == InitPulses - 1) ? waitClear : waitCommand;
	endfunction

	// Whole pin stream for the given characters
	function automatic pulseQT expectedNibbles(input byteQT chars);
		pulseQT stream;
		byteT   commands [4];
		commands = '{8'h28, 8'h06, 8'h0C, 8'h01};
		stream.push_back({1'b0, 4'h3});                  // Wake nibbles
		stream.push_back({1'b0, 4'h3});
		stream.push_back({1'b0, 4'h3});
		stream.push_back({1'b0, 4'h2});                  // 4-bit mode
		foreach (commands[i])
		begin
			stream.push_back({1'b0, commands[i][7:4]});
			stream.push_back({1'b0, commands[i][3:0]});
		end
		foreach (chars[i])
		begin
			stream.push_back({1'b1, chars[i][7:4]});     // Data, upper first
			stream.push_back({1'b1, chars[i][3:0]});
		end
		return stream;
	endfunction

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic checkCommand(input string name, input nibbleT expected, input nibbleT actual);
		if (actual !== expected)
		begin
			valueErrors++;
			$display("FAIL %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic checkChar(input string name, input byteT expected, input byteT actual);
		if (actual !== expected)
		begin
			valueErrors++;
			$display("FAIL %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic checkRegSelect(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			valueErrors++;
			$display("FAIL %s register select expected %b actual %b", name, expected, actual);
		end
	endtask

	task automatic checkReadWrite(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			valueErrors++;
			$display("FAIL %s read/write expected %b actual %b", name, expected, actual);
		end
	endtask

	task automatic checkGap(input string name, input int minimum, input int actual);
		if (actual < minimum)
		begin
			valueErrors++;
			$display("FAIL %s gap expected at least %0d actual %0d", name, minimum, actual);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Pin monitor and compare process
	////////////////////////////////////////////////////////////

	always @(posedge Clock)
	begin
		if (!rstN)
			cycleCount = 0;
		else
			cycleCount = cycleCount + 1;
		if (lcdEnable === 1'b1 && enablePrev !== 1'b1)
		begin
			checkReadWrite($sformatf("pulse %0d", pulseQ.size()), 1'b0, lcdReadWrite);
			pulseQ.push_back({lcdRegSelect, lcdData});
			pulseCycle.push_back(cycleCount);
		end
		if (dataReady === 1'b1 && pulseQ.size() < InitPulses && !readyEarlySeen)
		begin
			readyEarlySeen = 1'b1;                       // Report once
			protocolErrors++;
			$display("dataReady rose before the configuration pulses were done");
		end
		enablePrev = lcdEnable;
	end

	initial
	begin : compareStream
		int     idx;
		pulseQT expected;
		string  name;
		idx = 0;
		forever
		begin
			while (pulseQ.size() <= idx)
				@(negedge Clock);
			expected = expectedNibbles(sentQ);
			if (idx >= expected.size())
			begin
				protocolErrors++;
				$display("Enable pulse %0d appeared with no character accepted", idx);
				idx++;
			end
			else if (idx < InitPulses)
			begin
				name = $sformatf("init pulse %0d", idx);
				checkRegSelect(name, 1'b0, pulseQ[idx][4]);
				checkCommand(name, expected[idx][3:0], pulseQ[idx][3:0]);
				if (idx == 0)
					checkGap(name, waitLength(waitPowerOn), pulseCycle[0]);
				else
					checkGap(name, EnableCycles + waitLength(initWaitAfter(idx - 1)),
						pulseCycle[idx] - pulseCycle[idx - 1]);
				idx++;
			end
			else
			begin
				while (pulseQ.size() <= idx + 1)     // Lower nibble of the pair
					@(negedge Clock);
				name = $sformatf("char %0d", (idx - InitPulses) / 2);
				checkRegSelect(name, 1'b1, pulseQ[idx][4]);
				checkRegSelect(name, 1'b1, pulseQ[idx + 1][4]);
				checkChar(name, {expected[idx][3:0], expected[idx + 1][3:0]},
					{pulseQ[idx][3:0], pulseQ[idx + 1][3:0]});
				idx += 2;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// Starts at a falling edge, ends at one
	task automatic sendByte(input byteT value, input bit holdValid);
		dataIn = value;
		dataValid = 1'b1;
		forever
		begin
			@(posedge Clock);
			if (dataReady)
				break;                                   // Transfer on this edge
		end
		sentQ.push_back(value);
		@(negedge Clock);
		if (!holdValid)
			dataValid = 1'b0;
	endtask

	task automatic waitReady();
		while (dataReady !== 1'b1)
			@(negedge Clock);
	endtask

	initial
	begin
		rstN = 1'b0;
		dataIn = '0;
		dataValid = 1'b0;
		enablePrev = 1'b0;
		readyEarlySeen = 1'b0;
		valueErrors = 0;
		protocolErrors = 0;
		cycleCount = 0;
		seedValue = $urandom(17);
		repeat (8)
		begin
			@(negedge Clock);
			if (lcdEnable !== 1'b0 || dataReady !== 1'b0)
			begin
				protocolErrors++;
				$display("lcdEnable or dataReady not low during reset");
			end
		end
		rstN = 1'b1;
		waitReady();
		if (pulseQ.size() != InitPulses)
		begin
			protocolErrors++;
			$display("Saw %0d enable pulses before ready instead of %0d", pulseQ.size(), InitPulses);
		end
		for (int i = 0; i < CharCount; i++)
		begin
			sendByte(byteT'($urandom), 1'b0);
			repeat ($urandom_range(40)) @(negedge Clock);    // Idle gap
		end
		for (int i = 0; i < HoldCount; i++)
			sendByte(byteT'($urandom), (i != HoldCount - 1)); // Valid held across busy
		waitReady();
		repeat (4) @(negedge Clock);
		if (pulseQ.size() != InitPulses + 2 * sentQ.size())
		begin
			protocolErrors++;
			$display("Saw %0d enable pulses, %0d characters need %0d", pulseQ.size(),
				sentQ.size(), InitPulses + 2 * sentQ.size());
		end
		$display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Watchdog
	////////////////////////////////////////////////////////////

	initial
	begin : watchdog
		int initCycles;
		int dataStep;
		int limit;
		initCycles = waitLength(waitPowerOn) + 1;
		for (int i = 0; i < InitPulses; i++)
			initCycles += EnableCycles + waitLength(initWaitAfter(i)) + 1;
		dataStep = 2 * EnableCycles + waitLength(waitShort) + waitLength(waitCommand) + 2;
		limit = 2 * initCycles + (CharCount + HoldCount) * 2 * dataStep;
		repeat (limit) @(posedge Clock);
		$display("Run did not finish within %0d cycles", limit);
		$display("Test failed");
		$finish;
	end

endmodule

//--- vlog.f
logic/lcdPkg.sv
logic/lcdSequencer.sv
logic/lcdNibbleWriter.sv
logic/lcdController.sv
bench/lcdController_props.sv
bench/lcdControllerTb.sv

//--- Bender.yml
package:
  name: lcd_controller

sources:
  # Design, package first
  - files:
      - logic/lcdPkg.sv
      - logic/lcdSequencer.sv
      - logic/lcdNibbleWriter.sv
      - logic/lcdController.sv

  # Bench and bound properties
  - target: simulation
    files:
      - bench/lcdController_props.sv
      - bench/lcdControllerTb.sv
